// ==== bench/arm_dp_vectors.txt ====
# name kind w0 w1 w2 w3, all words in hex
# L: write w1 to offset w0    R: read offset w0, expect w1    E: write unmapped w0, expect pslverr
# X: execute w0, read offset w1 (expect w2) and flags (expect w3)    B: X with back-to-back read
add_carry     L 44       FFFFFFFF 00000000 00000000
add_carry     L 48       00000001 00000000 00000000
add_carry     X E0913002 4C       00000000 60000000
add_ovf       L 44       7FFFFFFF 00000000 00000000
add_ovf       X E0913002 4C       80000000 90000000
sub_ovf       L 44       80000000 00000000 00000000
sub_ovf       X E0513002 4C       7FFFFFFF 30000000
rsb_ovf       X E0714002 50       80000001 90000000
adc_carry     L 58       FFFFFFFF 00000000 00000000
adc_carry     L 04       30000000 00000000 00000000
adc_carry     X E0B65002 54       00000001 20000000
sbc_borrow    L 04       00000000 00000000 00000000
sbc_borrow    X E0D25002 54       FFFFFFFF 80000000
cmp_equal     X E1523002 4C       7FFFFFFF 60000000
rot_imm       L 04       10000000 00000000 00000000
rot_imm       X E3B074FF 5C       FF000000 B0000000
rot_imm_zero  X E3B0703F 5C       0000003F 30000000
asr_imm       L 60       80000001 00000000 00000000
asr_imm       X E1B09248 64       F8000000 90000000
lsl_imm       X E1B09088 64       00000002 30000000
ror_imm       X E1B09268 64       18000000 10000000
lsr_imm32     X E1B09028 64       00000000 70000000
rrx           X E1B09068 64       C0000000 B0000000
reg_lsl_0     X E1B09A18 64       80000001 B0000000
reg_lsl_32    L 6C       00000020 00000000 00000000
reg_lsl_32    X E1B09B18 64       00000000 70000000
reg_lsr_40    L 70       00000028 00000000 00000000
reg_lsr_40    X E1B09C38 64       00000000 50000000
cond_fail     L 04       10000000 00000000 00000000
cond_fail     X 0092D002 74       00000000 10000000
cond_pass     L 04       50000000 00000000 00000000
cond_pass     X 0092D002 74       00000002 00000000
tst_flags     X E111D002 74       00000002 40000000
teq_flags     X E131D002 74       00000002 80000000
cmn_flags     X E176D002 74       00000002 60000000
back_to_back  B E081E002 78       80000001 60000000
unmapped      E 08       FFFFFFFF 00000000 00000000
unmapped      E 42       FFFFFFFF 00000000 00000000
unmapped      E 80       FFFFFFFF 00000000 00000000
unmapped      R 40       00000000 00000000 00000000
unmapped      R 04       60000000 00000000 00000000
unmapped      R 00       E081E002 00000000 00000000

// ==== bench/tb_arm_dp.sv ====
// APB testbench driven by bench/arm_dp_vectors.txt, opened relative to the project root
`timescale 1ns/1ns
`include "arm_dp_cfg.svh"

module tb_arm_dp;

	localparam int WAIT_LIMIT = 20;             // Cycles allowed for pready per transfer

	logic              clk;
	logic              reset;
	logic              psel;
	logic              penable;
	logic              pwrite;
	logic [7:0]        paddr;
	logic [31:0]       pwdata;
	logic [31:0]       prdata;
	logic              pready;
	logic              pslverr;

	logic [8*128-1:0]  text_line;               // One raw line of the vector file
	logic [8*24-1:0]   name_r;
	logic [8*24-1:0]   cur_name;                // Test that is still open
	logic [7:0]        kind;
	logic [31:0]       w0;
	logic [31:0]       w1;
	logic [31:0]       w2;
	logic [31:0]       w3;
	logic [31:0]       rdata;                   // prdata of the last transfer
	logic              err;                     // pslverr of the last transfer
	logic [31:0]       lcg_state;
	logic              timed_out;
	logic              file_bad;
	int                fd;
	int                fields;
	int                test_errs;
	int                errors;
	int                checks;
	int                tests_run;
	int                tests_failed;

	arm_dp_top dut0 (
		.clk     (clk),
		.reset   (reset),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr)
	);

	always #20 clk = ~clk;                      // 40 ns period

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Zero to three idle cycles between transfers
	task automatic idle_gap();
		lcg_state = lcg_next(lcg_state);
		repeat (lcg_state[17:16]) begin
			@(posedge clk);
			#2;
		end
	endtask

	// Entered and left 2 ns after a rising edge, so transfers can run back to back
	task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] data);
		int waited;
		waited = 0;
		if (!timed_out) begin
			psel    = 1'b1;                     // Setup phase
			penable = 1'b0;
			pwrite  = wr;
			paddr   = addr;
			pwdata  = data;
			@(posedge clk);
			#2;
			penable = 1'b1;                     // Access phase
			@(negedge clk);                     // Outputs settled mid-cycle
			while (!pready && waited < WAIT_LIMIT) begin
				@(negedge clk);
				waited++;
			end
			rdata = prdata;
			err   = pslverr;
			if (!pready) begin
				$display("%0s: pready stayed low for %0d cycles at offset %h",
					cur_name, WAIT_LIMIT, addr);
				timed_out = 1'b1;
				test_errs++;
			end
			@(posedge clk);                     // Transfer completes on this edge
			#2;
			psel    = 1'b0;
			penable = 1'b0;
			pwrite  = 1'b0;
		end
	endtask

	task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
		if (!timed_out) begin
			checks++;
			assert (act === exp) else begin
				$display("ERROR %0s %0s: expected %h, actual %h", cur_name, what, exp, act);
				test_errs++;
				errors++;
			end
		end
	endtask

	task automatic close_test();
		tests_run++;
		if (test_errs == 0) begin
			$display("%0s: ok", cur_name);
		end else begin
			tests_failed++;
			$display("%0s: %0d failed checks", cur_name, test_errs);
		end
		test_errs = 0;
	endtask

	task automatic run_vector();
		case (kind)
			"L": begin                          // Register or flag load
				idle_gap();
				apb_xfer(1'b1, w0[7:0], w1);
				check_val("pslverr", 32'd0, {31'd0, err});
			end
			"X", "B": begin                     // Execute, then read result and flags
				idle_gap();
				apb_xfer(1'b1, `ARM_DP_INSTR_ADDR, w0);
				check_val("pslverr", 32'd0, {31'd0, err});
				if (kind == "X") begin
					idle_gap();                 // B reads right after the INSTR write
				end
				apb_xfer(1'b0, w1[7:0], 32'd0);
				check_val("result", w2, rdata);
				idle_gap();
				apb_xfer(1'b0, `ARM_DP_FLAGS_ADDR, 32'd0);
				check_val("flags", w3, rdata);
			end
			"R": begin
				idle_gap();
				apb_xfer(1'b0, w0[7:0], 32'd0);
				check_val("read", w1, rdata);
			end
			"E": begin                          // Unmapped offset
				idle_gap();
				apb_xfer(1'b1, w0[7:0], w1);
				check_val("pslverr", 32'd1, {31'd0, err});
			end
			default: begin
				$display("%0s: vector kind %s is not known", cur_name, kind);
				test_errs++;
				errors++;
			end
		endcase
	endtask

	initial begin
		clk          = 1'b0;
		reset        = 1'b1;
		psel         = 1'b0;
		penable      = 1'b0;
		pwrite       = 1'b0;
		paddr        = '0;
		pwdata       = '0;
		lcg_state    = 32'h614b;
		timed_out    = 1'b0;
		file_bad     = 1'b0;
		cur_name     = '0;
		test_errs    = 0;
		errors       = 0;
		checks       = 0;
		tests_run    = 0;
		tests_failed = 0;
		repeat (5) @(posedge clk);
		#2;
		reset = 1'b0;
		fd = $fopen("bench/arm_dp_vectors.txt", "r");
		if (fd == 0) begin
			$display("vector file bench/arm_dp_vectors.txt could not be opened");
			file_bad = 1'b1;
		end else begin
			while (!$feof(fd) && !timed_out) begin
				text_line = '0;
				if ($fgets(text_line, fd) != 0) begin
					name_r = '0;
					fields = $sscanf(text_line, "%s %s %h %h %h %h", name_r, kind, w0, w1, w2, w3);
					if (fields == 6 && name_r[7:0] != "#") begin     // Skip comments
						if (name_r != cur_name && cur_name != '0) begin
							close_test();
						end
						cur_name = name_r;
						run_vector();
					end
				end
			end
			$fclose(fd);
		end
		if (cur_name != '0) begin
			close_test();
		end
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0 && !timed_out && !file_bad && tests_run > 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+include
source/arm_dp_pkg.sv
source/operand_bus_if.sv
source/apb_host_port.sv
source/shifter_operand_unit.sv
source/cond_decode_unit.sv
source/dp_execute_unit.sv
source/arm_dp_top.sv
bench/tb_arm_dp.sv

// ==== include/arm_dp_cfg.svh ====
// APB map and widths; APB addresses are word aligned only, byte lanes are not supported
`ifndef ARM_DP_CFG_SVH
`define ARM_DP_CFG_SVH

// Bus widths
`define ARM_DP_ADDR_W     8         // APB address width
`define ARM_DP_DATA_W     32        // Register and APB data width

// Register bank size
`define ARM_DP_NUM_REGS   16        // R0 to R15, R15 is a plain register

// Address map, byte offsets
`define ARM_DP_INSTR_ADDR 8'h00     // Write executes, read returns last instruction
`define ARM_DP_FLAGS_ADDR 8'h04     // NZCV in bits 31:28
`define ARM_DP_REG_BASE   8'h40     // Rn at base + 4*n

// Host select encoding toward the execute unit
`define ARM_DP_SEL_W      5         // One extra bit above the register index
`define ARM_DP_FLAGS_SEL  5'd16     // Select value for the flag register

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it from the project root and checks the log

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --assert -j 0 --top-module tb_arm_dp -Mdir "$build_dir" -f files.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$build_dir/Vtb_arm_dp" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^=== PASS ===$" "$log"; then
	echo "Result: pass"
	exit 0
fi
echo "Result: fail"
exit 1

// ==== source/apb_host_port.sv ====
// APB slave for the engine; no byte strobes, one instruction in flight, pready low while busy
`timescale 1ns/1ns
`include "arm_dp_cfg.svh"

module apb_host_port (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        psel,
	input  logic                        penable,
	input  logic                        pwrite,
	input  logic [`ARM_DP_ADDR_W-1:0]   paddr,
	input  logic [`ARM_DP_DATA_W-1:0]   pwdata,
	input  logic                        busy,
	input  logic [`ARM_DP_DATA_W-1:0]   rd_data,
	output logic [`ARM_DP_DATA_W-1:0]   prdata,
	output logic                        pready,
	output logic                        pslverr,
	output logic                        start,
	output arm_dp_pkg::dp_instr_u       instr,
	output logic                        host_wr,
	output logic [`ARM_DP_SEL_W-1:0]    host_rd_sel,
	output logic [`ARM_DP_DATA_W-1:0]   host_wdata
);

	logic                       access;         // APB access phase
	logic                       done;           // Transfer completes this cycle
	logic                       hit_instr;
	logic                       hit_flags;
	logic                       hit_reg;
	logic                       addr_ok;
	logic                       instr_wr;       // Completed write to INSTR
	logic [`ARM_DP_ADDR_W-1:0]  reg_off;        // Offset into the register window

	assign access    = psel & penable;
	assign hit_instr = paddr == `ARM_DP_INSTR_ADDR;
	assign hit_flags = paddr == `ARM_DP_FLAGS_ADDR;
	assign reg_off   = paddr - `ARM_DP_REG_BASE;
	assign hit_reg   = (paddr >= `ARM_DP_REG_BASE)
		&& (reg_off < `ARM_DP_ADDR_W'(4 * `ARM_DP_NUM_REGS))
		&& (reg_off[1:0] == 2'b00);             // Word aligned only
	assign addr_ok   = hit_instr | hit_flags | hit_reg;

	assign pready    = ~busy;                   // Stall until commit
	assign done      = access & pready;
	assign pslverr   = done & ~addr_ok;         // Unmapped, no side effect
	assign instr_wr  = done & pwrite & hit_instr;

	// Register and flag access toward the execute unit
	assign host_rd_sel = hit_flags ? `ARM_DP_FLAGS_SEL : {1'b0, reg_off[5:2]};
	assign host_wr     = done & pwrite & (hit_flags | hit_reg);
	assign host_wdata  = pwdata;

	always_comb begin
		if (hit_instr) begin
			prdata = instr;                     // Last instruction written
		end else if (hit_flags || hit_reg) begin
			prdata = rd_data;
		end else begin
			prdata = '0;
		end
	end

	// Instruction latch and start pulse one cycle after the access phase
	always_ff @(posedge clk) begin
		if (reset) begin
			start <= 1'b0;
			instr <= '0;
		end else begin
			start <= instr_wr;
			if (instr_wr) begin
				instr <= pwdata;
			end
		end
	end

	// APB protocol: enable only inside a selected transfer
	a_penable_needs_psel: assert property (
		@(posedge clk) disable iff (reset) penable |-> psel
	) else $error("penable high without psel");

endmodule

// ==== source/arm_dp_pkg.sv ====
// Shared types for the data-processing engine; only the ARMv4 data-processing family is modeled
package arm_dp_pkg;

	// Data-processing opcodes, bits 24:21
	typedef enum logic [3:0] {
		op_and = 4'h0,
		op_eor = 4'h1,
		op_sub = 4'h2,
		op_rsb = 4'h3,
		op_add = 4'h4,
		op_adc = 4'h5,
		op_sbc = 4'h6,
		op_rsc = 4'h7,
		op_tst = 4'h8,
		op_teq = 4'h9,
		op_cmp = 4'ha,
		op_cmn = 4'hb,
		op_orr = 4'hc,
		op_mov = 4'hd,
		op_bic = 4'he,
		op_mvn = 4'hf
	} alu_op_e;

	typedef struct packed {
		logic n;                    // Negative
		logic z;                    // Zero
		logic c;                    // Carry, not-borrow on subtract
		logic v;                    // Signed overflow
	} nzcv_t;

	// Immediate form, I bit set
	typedef struct packed {
		logic [3:0] cond;
		logic [1:0] cls;            // 00 for data processing
		logic       i_bit;
		alu_op_e    opcode;
		logic       s;
		logic [3:0] rn;
		logic [3:0] rd;
		logic [3:0] rotate;         // Rotate right by twice this
		logic [7:0] imm8;
	} dp_imm_t;

	// Shifted register form, I bit clear
	typedef struct packed {
		logic [3:0] cond;
		logic [1:0] cls;
		logic       i_bit;
		alu_op_e    opcode;
		logic       s;
		logic [3:0] rn;
		logic [3:0] rd;
		logic [4:0] shift_fld;      // shift_imm, or Rs in [4:1] with [0] zero
		logic [1:0] shift_type;     // LSL LSR ASR ROR
		logic       reg_shift;      // Amount comes from Rs
		logic [3:0] rm;
	} dp_reg_t;

	typedef union packed {
		dp_imm_t imm;
		dp_reg_t shf;
	} dp_instr_u;

	typedef struct packed {
		logic is_logical;           // C from shifter, V kept
		logic is_test;              // No register writeback
		logic uses_rn;              // Clear for MOV and MVN
	} op_class_t;

endpackage

// ==== source/arm_dp_top.sv ====
// Engine top with plain APB ports; one data-processing instruction executes per INSTR write
`timescale 1ns/1ns
`include "arm_dp_cfg.svh"

module arm_dp_top (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        psel,
	input  logic                        penable,
	input  logic                        pwrite,
	input  logic [`ARM_DP_ADDR_W-1:0]   paddr,
	input  logic [`ARM_DP_DATA_W-1:0]   pwdata,
	output logic [`ARM_DP_DATA_W-1:0]   prdata,
	output logic                        pready,
	output logic                        pslverr
);

	logic                       start;          // Execute pulse
	arm_dp_pkg::dp_instr_u      instr;
	logic                       host_wr;
	logic [`ARM_DP_SEL_W-1:0]   host_rd_sel;    // Register index or flags
	logic [`ARM_DP_DATA_W-1:0]  host_wdata;
	logic                       busy;
	logic [`ARM_DP_DATA_W-1:0]  rd_data;

	operand_bus_if op_bus ();                   // Shared combinational operands

	apb_host_port host0 (
		.clk         (clk),
		.reset       (reset),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.paddr       (paddr),
		.pwdata      (pwdata),
		.busy        (busy),
		.rd_data     (rd_data),
		.prdata      (prdata),
		.pready      (pready),
		.pslverr     (pslverr),
		.start       (start),
		.instr       (instr),
		.host_wr     (host_wr),
		.host_rd_sel (host_rd_sel),
		.host_wdata  (host_wdata)
	);

	shifter_operand_unit shift0 (
		.bus (op_bus.shifter)
	);

	cond_decode_unit cond0 (
		.bus (op_bus.cond)
	);

	dp_execute_unit exec0 (
		.clk         (clk),
		.reset       (reset),
		.start       (start),
		.instr       (instr),
		.host_wr     (host_wr),
		.host_rd_sel (host_rd_sel),
		.host_wdata  (host_wdata),
		.busy        (busy),
		.rd_data     (rd_data),
		.bus         (op_bus.exec)
	);

endmodule

// ==== source/cond_decode_unit.sv ====
// Condition check and opcode class, combinational; condition 1111 never passes
`timescale 1ns/1ns

module cond_decode_unit (
	operand_bus_if.cond bus
);

	arm_dp_pkg::nzcv_t   f;
	arm_dp_pkg::alu_op_e op;
	logic                pass;
	logic                logical;

	assign f  = bus.flags;
	assign op = bus.instr.imm.opcode;

	always_comb begin
		unique case (bus.instr.imm.cond)
			4'h0: pass = f.z;                       // EQ
			4'h1: pass = !f.z;                      // NE
			4'h2: pass = f.c;                       // CS
			4'h3: pass = !f.c;                      // CC
			4'h4: pass = f.n;                       // MI
			4'h5: pass = !f.n;                      // PL
			4'h6: pass = f.v;                       // VS
			4'h7: pass = !f.v;                      // VC
			4'h8: pass = f.c && !f.z;               // HI
			4'h9: pass = !f.c || f.z;               // LS
			4'ha: pass = f.n == f.v;                // GE
			4'hb: pass = f.n != f.v;                // LT
			4'hc: pass = !f.z && (f.n == f.v);      // GT
			4'hd: pass = f.z || (f.n != f.v);       // LE
			4'he: pass = 1'b1;                      // AL
			default: pass = 1'b0;                   // NV
		endcase
	end

	// Logical group takes its carry from the shifter
	always_comb begin
		unique case (op)
			arm_dp_pkg::op_and, arm_dp_pkg::op_eor,
			arm_dp_pkg::op_tst, arm_dp_pkg::op_teq,
			arm_dp_pkg::op_orr, arm_dp_pkg::op_mov,
			arm_dp_pkg::op_bic, arm_dp_pkg::op_mvn: logical = 1'b1;
			default: logical = 1'b0;                // Adder ops
		endcase
	end

	assign bus.cond_pass           = pass;
	assign bus.op_class.is_logical = logical;
	assign bus.op_class.is_test    = op[3:2] == 2'b10;      // TST TEQ CMP CMN
	assign bus.op_class.uses_rn    = (op != arm_dp_pkg::op_mov) && (op != arm_dp_pkg::op_mvn);

endmodule

// ==== source/dp_execute_unit.sv ====
// Register bank, ALU and NZCV; R15 is a plain register, host access only while not busy
`timescale 1ns/1ns
`include "arm_dp_cfg.svh"

module dp_execute_unit (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        start,
	input  arm_dp_pkg::dp_instr_u       instr,
	input  logic                        host_wr,
	input  logic [`ARM_DP_SEL_W-1:0]    host_rd_sel,
	input  logic [`ARM_DP_DATA_W-1:0]   host_wdata,
	output logic                        busy,
	output logic [`ARM_DP_DATA_W-1:0]   rd_data,
	operand_bus_if.exec                 bus
);

	logic [`ARM_DP_DATA_W-1:0]  regs [`ARM_DP_NUM_REGS];
	arm_dp_pkg::nzcv_t          flags;
	arm_dp_pkg::nzcv_t          new_flags;
	logic [3:0]                 rd_idx;
	logic [`ARM_DP_DATA_W-1:0]  rn_data;
	logic [`ARM_DP_DATA_W-1:0]  op_a;           // First operand, zero for MOV/MVN
	logic [`ARM_DP_DATA_W-1:0]  op_b;           // Shifter operand
	logic [`ARM_DP_DATA_W-1:0]  add_a;
	logic [`ARM_DP_DATA_W-1:0]  add_b;
	logic                       add_cin;
	logic [`ARM_DP_DATA_W:0]    add_full;       // Carry in the top bit
	logic                       add_v;
	logic [`ARM_DP_DATA_W-1:0]  logic_res;
	logic [`ARM_DP_DATA_W-1:0]  result;
	logic                       do_commit;
	logic                       reg_we;
	logic                       flag_we;
	logic                       host_reg_wr;
	logic                       host_flag_wr;

	assign busy = start;                    // Single-cycle execute

	// Operand reads onto the shared bus
	assign bus.instr   = instr;
	assign bus.rm_data = regs[instr.shf.rm];
	assign bus.rs_data = regs[instr.shf.shift_fld[4:1]];
	assign bus.flags   = flags;

	assign rd_idx  = instr.imm.rd;
	assign rn_data = regs[instr.imm.rn];
	assign op_a    = bus.op_class.uses_rn ? rn_data : '0;
	assign op_b    = bus.shifter_operand;

	always_comb begin
		add_a     = op_a;
		add_b     = op_b;
		add_cin   = 1'b0;
		logic_res = '0;
		unique case (instr.imm.opcode)
			arm_dp_pkg::op_and, arm_dp_pkg::op_tst: logic_res = op_a & op_b;
			arm_dp_pkg::op_eor, arm_dp_pkg::op_teq: logic_res = op_a ^ op_b;
			arm_dp_pkg::op_orr: logic_res = op_a | op_b;
			arm_dp_pkg::op_mov: logic_res = op_b;
			arm_dp_pkg::op_bic: logic_res = op_a & ~op_b;
			arm_dp_pkg::op_mvn: logic_res = ~op_b;
			arm_dp_pkg::op_sub, arm_dp_pkg::op_cmp: begin
				add_b   = ~op_b;                // A - B as A + ~B + 1
				add_cin = 1'b1;
			end
			arm_dp_pkg::op_rsb: begin
				add_a   = op_b;
				add_b   = ~op_a;
				add_cin = 1'b1;
			end
			arm_dp_pkg::op_adc: add_cin = flags.c;
			arm_dp_pkg::op_sbc: begin
				add_b   = ~op_b;
				add_cin = flags.c;              // Borrow is not-C
			end
			arm_dp_pkg::op_rsc: begin
				add_a   = op_b;
				add_b   = ~op_a;
				add_cin = flags.c;
			end
			default: ;                          // ADD and CMN, plain sum
		endcase
	end

	assign add_full = {1'b0, add_a} + {1'b0, add_b} + {{`ARM_DP_DATA_W{1'b0}}, add_cin};
	assign add_v    = (add_a[31] == add_b[31]) && (add_full[31] != add_a[31]);
	assign result   = bus.op_class.is_logical ? logic_res : add_full[`ARM_DP_DATA_W-1:0];

	// Flag update per class
	assign new_flags.n = result[31];
	assign new_flags.z = result == '0;
	assign new_flags.c = bus.op_class.is_logical ? bus.shifter_carry : add_full[`ARM_DP_DATA_W];
	assign new_flags.v = bus.op_class.is_logical ? flags.v : add_v;

	// Commit at the end of the start cycle
	assign do_commit    = start & bus.cond_pass;
	assign reg_we       = do_commit & ~bus.op_class.is_test;
	assign flag_we      = do_commit & instr.imm.s;
	assign host_reg_wr  = host_wr & ~busy & (host_rd_sel < `ARM_DP_FLAGS_SEL);
	assign host_flag_wr = host_wr & ~busy & (host_rd_sel == `ARM_DP_FLAGS_SEL);

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `ARM_DP_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
			flags <= '0;
		end else begin
			if (reg_we) begin
				regs[rd_idx] <= result;
			end else if (host_reg_wr) begin
				regs[host_rd_sel[3:0]] <= host_wdata;
			end
			if (flag_we) begin
				flags <= new_flags;
			end else if (host_flag_wr) begin
				flags <= host_wdata[31:28];         // NZCV from the top nibble
			end
		end
	end

	// Host read mux, flags in the top nibble
	assign rd_data = (host_rd_sel == `ARM_DP_FLAGS_SEL)
		? {flags, {(`ARM_DP_DATA_W-4){1'b0}}}
		: regs[host_rd_sel[3:0]];

	// Failed condition from the decode unit leaves Rd and NZCV untouched
	a_no_write_on_fail: assert property (
		@(posedge clk) disable iff (reset)
		start && !bus.cond_pass |=>
			(regs[$past(rd_idx)] == $past(regs[rd_idx])) && (flags == $past(flags))
	) else $error("state changed by a failed condition");

endmodule

// ==== source/operand_bus_if.sv ====
// Combinational operand bus between execute unit, shifter and condition decode; no clock
`timescale 1ns/1ns
`include "arm_dp_cfg.svh"

interface operand_bus_if;
	arm_dp_pkg::dp_instr_u       instr;             // Current instruction word
	logic [`ARM_DP_DATA_W-1:0]   rm_data;           // Value of Rm
	logic [`ARM_DP_DATA_W-1:0]   rs_data;           // Value of Rs
	arm_dp_pkg::nzcv_t           flags;             // Flags before execution
	logic [`ARM_DP_DATA_W-1:0]   shifter_operand;   // Second ALU operand
	logic                        shifter_carry;     // Carry out of the shifter
	logic                        cond_pass;         // Condition field satisfied
	arm_dp_pkg::op_class_t       op_class;          // Opcode class bits

	modport exec (
		output instr, rm_data, rs_data, flags,
		input  shifter_operand, shifter_carry, cond_pass, op_class
	);

	modport shifter (
		input  instr, rm_data, rs_data, flags,
		output shifter_operand, shifter_carry
	);

	modport cond (
		input  instr, flags,
		output cond_pass, op_class
	);

endinterface

// ==== source/shifter_operand_unit.sv ====
// Addressing mode 1 shifter, purely combinational; register shift uses only the low byte of Rs
`timescale 1ns/1ns

module shifter_operand_unit (
	operand_bus_if.shifter bus
);

	logic        c_in;              // Current C flag
	logic [31:0] rm;
	logic [31:0] imm_val;
	logic [63:0] imm_pair;          // Doubled word for rotation
	logic [31:0] imm_op;
	logic        imm_c;
	logic [1:0]  sh_type;
	logic        reg_shift;
	logic [7:0]  amt_raw;           // Shift amount as encoded
	logic [8:0]  amt;               // Effective amount, 32 for LSR/ASR #0
	logic        keep;              // Amount zero, operand passes unchanged
	logic        rrx;               // ROR #0 in immediate form
	logic [32:0] lsl_w;             // Carry in bit 32
	logic [32:0] lsr_w;             // Carry in bit 0
	logic [32:0] asr_w;             // Carry in bit 0
	logic [63:0] ror_pair;
	logic [31:0] sh_op;
	logic        sh_c;

	assign c_in      = bus.flags.c;
	assign rm        = bus.rm_data;
	assign sh_type   = bus.instr.shf.shift_type;
	assign reg_shift = bus.instr.shf.reg_shift;

	// Immediate form, imm8 rotated right by 2*rotate
	assign imm_val  = {24'h000000, bus.instr.imm.imm8};
	assign imm_pair = {imm_val, imm_val} >> {bus.instr.imm.rotate, 1'b0};
	assign imm_op   = imm_pair[31:0];
	assign imm_c    = (bus.instr.imm.rotate == 4'h0) ? c_in : imm_op[31];

	// Amount from shift_imm or bottom byte of Rs
	assign amt_raw = reg_shift ? bus.rs_data[7:0] : {3'b000, bus.instr.shf.shift_fld};
	assign amt     = (!reg_shift && amt_raw == 8'h00) ? 9'd32 : {1'b0, amt_raw};
	assign keep    = (amt_raw == 8'h00) && (reg_shift || sh_type == 2'b00);
	assign rrx     = !reg_shift && sh_type == 2'b11 && amt_raw == 8'h00;

	// Extra bit catches the last bit shifted out; >=32 falls out naturally
	assign lsl_w    = {1'b0, rm} << amt;
	assign lsr_w    = {rm, 1'b0} >> amt;
	assign asr_w    = 33'($signed({rm, 1'b0}) >>> amt);
	assign ror_pair = {rm, rm} >> amt_raw[4:0];     // Multiples of 32 give rm

	always_comb begin
		unique case (sh_type)
			2'b00: {sh_c, sh_op} = lsl_w;               // LSL
			2'b01: {sh_op, sh_c} = lsr_w;               // LSR
			2'b10: {sh_op, sh_c} = asr_w;               // ASR
			default: begin                              // ROR or RRX
				sh_op = rrx ? {c_in, rm[31:1]} : ror_pair[31:0];
				sh_c  = rrx ? rm[0] : sh_op[31];
			end
		endcase
		if (keep) begin
			sh_op = rm;                                 // LSL #0 or Rs byte zero
			sh_c  = c_in;
		end
	end

	assign bus.shifter_operand = bus.instr.imm.i_bit ? imm_op : sh_op;
	assign bus.shifter_carry   = bus.instr.imm.i_bit ? imm_c : sh_c;

endmodule
